// File: common/uart_bus_pkg.sv
//--------------------
// register bus and serial timing shared by the UART and both bus masters
// frame format is fixed at 8N1, CLKS_PER_BIT must be even and at least 2
//--------------------

package uart_bus_pkg;

    // register bus
    typedef logic [1:0] bus_addr_t;
    typedef logic [7:0] bus_data_t;

    // THR and RBR share offset 0 as on a 16550, direction picks the register
    localparam bus_addr_t ADDR_THR = 2'd0;   // write only
    localparam bus_addr_t ADDR_RBR = 2'd0;   // read only

    // serial timing, short bit period keeps simulation fast
    localparam int CLKS_PER_BIT = 8;
    localparam int BAUD_HALF    = CLKS_PER_BIT / 2;
    localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);
    localparam int FRAME_BITS   = 10;         // start + 8 data + stop

    typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;

endpackage

// File: common/telemetry_pkg.sv
//--------------------
// telemetry words and the text line format of one dump
// every word prints as one 8 character line
//--------------------

package telemetry_pkg;

    typedef logic [15:0] telem_word_t;
    typedef logic [7:0]  char_t;

    localparam int TELEM_WORDS    = 8;
    localparam int CHARS_PER_WORD = 8;   // 2 index, 4 value, lf, cr
    localparam int WORD_IDX_W     = $clog2(TELEM_WORDS);
    localparam int CHAR_IDX_W     = $clog2(CHARS_PER_WORD);

    // full telemetry input, word 0 in the low bits
    typedef telem_word_t [TELEM_WORDS-1:0] telem_set_t;

    localparam char_t CHAR_LF  = 8'h0a;
    localparam char_t CHAR_CR  = 8'h0d;
    localparam char_t CMD_DUMP = 8'h44;  // 'D' starts a dump

endpackage

// File: uart/uart_tx.sv
//--------------------
// 8N1 transmitter, load_i is ignored while busy_o is high
//--------------------

`timescale 1ns/1ps

module uart_tx
    import uart_bus_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      load_i,
    input  bus_data_t data_i,
    output logic      sout_o,
    output logic      busy_o
);

    baud_cnt_t  baud_cnt;
    logic [3:0] bit_cnt;    // 0 start, 1..8 data, 9 stop
    logic [8:0] shift_q;    // remaining data bits with stop bit on top

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy_o   <= 1'b0;
            sout_o   <= 1'b1;   // line idles high
            baud_cnt <= '0;
            bit_cnt  <= '0;
            shift_q  <= '1;
        end else if (!busy_o) begin
            if (load_i) begin
                busy_o   <= 1'b1;
                sout_o   <= 1'b0;   // start bit
                baud_cnt <= '0;
                bit_cnt  <= '0;
                shift_q  <= {1'b1, data_i};
            end
        end else if (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1)) begin
            baud_cnt <= '0;
            if (bit_cnt == 4'(FRAME_BITS - 1)) begin
                busy_o <= 1'b0;     // stop bit done
            end else begin
                // next bit out, lsb first
                sout_o  <= shift_q[0];
                shift_q <= {1'b1, shift_q[8:1]};
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

// File: uart/uart_rx.sv
//--------------------
// 8N1 receiver, one valid_o pulse per good frame
// a frame with a low stop bit is dropped without notice
//--------------------

`timescale 1ns/1ps

module uart_rx
    import uart_bus_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      sin_i,
    output bus_data_t data_o,
    output logic      valid_o
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t  state;
    logic       sin_meta;
    logic       sin_sync;
    baud_cnt_t  baud_cnt;
    logic [2:0] bit_cnt;
    bus_data_t  shift_q;
    logic       bit_mid;

    assign bit_mid = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
    assign data_o  = shift_q;   // stable from end of data bits to next frame

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            sin_meta <= 1'b1;
            sin_sync <= 1'b1;
        end else begin
            sin_meta <= sin_i;
            sin_sync <= sin_meta;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            valid_o  <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (!sin_sync) state <= RX_START;   // falling edge seen
                end
                RX_START: begin
                    if (baud_cnt == baud_cnt_t'(BAUD_HALF - 1)) begin
                        // middle of start bit, high again means a glitch
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= sin_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_mid) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) state <= RX_STOP;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_mid) begin
                        state   <= RX_IDLE;
                        valid_o <= sin_sync;   // framing check
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_mid) shift_q <= {sin_sync, shift_q[7:1]};
    end

endmodule

// File: uart/uart_core.sv
//--------------------
// minimal UART register slave, THR write and RBR read only
// a THR write while txrdy_n_o is high is lost
//--------------------

`timescale 1ns/1ps

module uart_core
    import uart_bus_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      req_i,
    input  logic      we_i,
    input  bus_addr_t addr_i,
    input  bus_data_t wdata_i,
    output logic      ack_o,
    output bus_data_t rdata_o,
    input  logic      sin_i,
    output logic      sout_o,
    output logic      rxrdy_n_o,
    output logic      txrdy_n_o
);

    logic      tx_load;
    logic      tx_busy;
    logic      rd_rbr;
    logic      rx_valid;
    logic      rx_ready;
    bus_data_t rx_data;
    bus_data_t rx_buf;

    // decode only in the first cycle of a request
    assign tx_load = req_i & ~ack_o & we_i & (addr_i == ADDR_THR);
    assign rd_rbr  = req_i & ~ack_o & ~we_i & (addr_i == ADDR_RBR);

    assign rxrdy_n_o = ~rx_ready;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ack_o     <= 1'b0;
            rx_ready  <= 1'b0;
            txrdy_n_o <= 1'b1;   // not ready until out of reset
        end else begin
            ack_o     <= req_i & ~ack_o;
            txrdy_n_o <= tx_busy | tx_load;
            if (rx_valid) begin
                rx_ready <= 1'b1;    // new byte wins over a read
            end else if (rd_rbr) begin
                rx_ready <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid) rx_buf <= rx_data;   // unread byte is overwritten
        if (rd_rbr) rdata_o <= rx_buf;
    end

    uart_tx u_tx (
        .clk    (clk),
        .resetn (resetn),
        .load_i (tx_load),
        .data_i (wdata_i),
        .sout_o (sout_o),
        .busy_o (tx_busy)
    );

    uart_rx u_rx (
        .clk     (clk),
        .resetn  (resetn),
        .sin_i   (sin_i),
        .data_o  (rx_data),
        .valid_o (rx_valid)
    );

endmodule

// File: design/bus_arbiter.sv
//--------------------
// two master round-robin arbiter, grant held until the slave acks
//--------------------

`timescale 1ns/1ps

module bus_arbiter
    import uart_bus_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      dmp_req_i,
    input  logic      dmp_we_i,
    input  bus_addr_t dmp_addr_i,
    input  bus_data_t dmp_wdata_i,
    output logic      dmp_ack_o,
    input  logic      con_req_i,
    input  logic      con_we_i,
    input  bus_addr_t con_addr_i,
    input  bus_data_t con_wdata_i,
    output logic      con_ack_o,
    output logic      bus_req_o,
    output logic      bus_we_o,
    output bus_addr_t bus_addr_o,
    output bus_data_t bus_wdata_o,
    input  logic      bus_ack_i
);

    logic locked;
    logic grant_con;   // 1 selects the console reader
    logic last_con;
    logic pick_con;
    logic sel_con;

    // on a tie the master not served last wins
    assign pick_con = (dmp_req_i && con_req_i) ? ~last_con : con_req_i;
    assign sel_con  = locked ? grant_con : pick_con;

    assign bus_req_o   = sel_con ? con_req_i   : dmp_req_i;
    assign bus_we_o    = sel_con ? con_we_i    : dmp_we_i;
    assign bus_addr_o  = sel_con ? con_addr_i  : dmp_addr_i;
    assign bus_wdata_o = sel_con ? con_wdata_i : dmp_wdata_i;

    assign dmp_ack_o = bus_ack_i & ~sel_con;
    assign con_ack_o = bus_ack_i & sel_con;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            locked    <= 1'b0;
            grant_con <= 1'b0;
            last_con  <= 1'b1;   // dumper first on a tie
        end else if (locked) begin
            if (bus_ack_i) begin
                locked   <= 1'b0;
                last_con <= grant_con;
            end
        end else if (dmp_req_i || con_req_i) begin
            locked    <= 1'b1;
            grant_con <= pick_con;
        end
    end

endmodule

// File: design/telemetry_dumper.sv
//--------------------
// prints all telemetry words as hex text lines, one THR write per char
// triggers during a dump are dropped, values are read per character
//--------------------

`timescale 1ns/1ps

module telemetry_dumper
    import uart_bus_pkg::*;
    import telemetry_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       start_i,
    input  logic       dump_req_i,
    input  telem_set_t telem_i,
    input  logic       txrdy_n_i,
    output logic       busy_o,
    output logic       req_o,
    output logic       we_o,
    output bus_addr_t  addr_o,
    output char_t      wdata_o,
    input  logic       ack_i
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_RDY,
        ST_WRITE,
        ST_WAIT_BUSY,
        ST_NEXT
    } state_t;

    state_t                state;
    logic [WORD_IDX_W-1:0] word_idx;
    logic [CHAR_IDX_W-1:0] char_idx;
    logic [7:0]            idx_byte;
    telem_word_t           cur_word;
    char_t                 cur_char;
    logic                  last_char;

    // uppercase hex digit
    function automatic char_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return "0" + {4'h0, nib};
        end
        return "A" + {4'h0, nib} - 8'd10;
    endfunction

    assign idx_byte  = 8'(word_idx);
    assign cur_word  = telem_i[word_idx];
    assign last_char = (word_idx == WORD_IDX_W'(TELEM_WORDS - 1)) &&
                       (char_idx == CHAR_IDX_W'(CHARS_PER_WORD - 1));

    // line layout: ii vvvv lf cr
    always_comb begin
        case (char_idx)
            3'd0:    cur_char = hex_char(idx_byte[7:4]);
            3'd1:    cur_char = hex_char(idx_byte[3:0]);
            3'd2:    cur_char = hex_char(cur_word[15:12]);
            3'd3:    cur_char = hex_char(cur_word[11:8]);
            3'd4:    cur_char = hex_char(cur_word[7:4]);
            3'd5:    cur_char = hex_char(cur_word[3:0]);
            3'd6:    cur_char = CHAR_LF;
            default: cur_char = CHAR_CR;
        endcase
    end

    assign busy_o = (state != ST_IDLE);
    assign req_o  = (state == ST_WRITE);
    assign we_o   = 1'b1;
    assign addr_o = ADDR_THR;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= ST_IDLE;
            word_idx <= '0;
            char_idx <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_i || dump_req_i) begin
                        state    <= ST_WAIT_RDY;
                        word_idx <= '0;
                        char_idx <= '0;
                    end
                end
                ST_WAIT_RDY: begin
                    if (!txrdy_n_i) state <= ST_WRITE;
                end
                ST_WRITE: begin
                    if (ack_i) state <= last_char ? ST_IDLE : ST_WAIT_BUSY;
                end
                ST_WAIT_BUSY: begin
                    if (txrdy_n_i) state <= ST_NEXT;   // transmitter took the char
                end
                ST_NEXT: begin
                    state <= ST_WAIT_RDY;
                    if (char_idx == CHAR_IDX_W'(CHARS_PER_WORD - 1)) begin
                        char_idx <= '0;
                        word_idx <= word_idx + 1'b1;
                    end else begin
                        char_idx <= char_idx + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // char is formatted when the transmitter is free
    always_ff @(posedge clk) begin
        if (state == ST_WAIT_RDY && !txrdy_n_i) wdata_o <= cur_char;
    end

endmodule

// File: design/console_reader.sv
//--------------------
// drains the UART receive buffer, flags the dump command
//--------------------

`timescale 1ns/1ps

module console_reader
    import uart_bus_pkg::*;
    import telemetry_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      rxrdy_n_i,
    output logic      req_o,
    output logic      we_o,
    output bus_addr_t addr_o,
    input  logic      ack_i,
    input  bus_data_t rdata_i,
    output logic      dump_req_o
);

    typedef enum logic {
        ST_IDLE,
        ST_READ
    } state_t;

    state_t state;

    assign req_o  = (state == ST_READ);
    assign we_o   = 1'b0;
    assign addr_o = ADDR_RBR;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= ST_IDLE;
            dump_req_o <= 1'b0;
        end else begin
            dump_req_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (!rxrdy_n_i) state <= ST_READ;   // byte waiting
                end
                default: begin
                    if (ack_i) begin
                        state      <= ST_IDLE;
                        dump_req_o <= (rdata_i == CMD_DUMP);
                    end
                end
            endcase
        end
    end

endmodule

// File: design/debug_uart_top.sv
//--------------------
// debug telemetry port, dump on start_i or 'D' received on sin_i
//--------------------

`timescale 1ns/1ps

module debug_uart_top
    import uart_bus_pkg::*;
    import telemetry_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       start_i,
    input  logic       sin_i,
    input  telem_set_t telem_i,
    output logic       sout_o,
    output logic       rxrdy_n_o,
    output logic       txrdy_n_o,
    output logic       busy_o
);

    // dumper side
    logic      dmp_req;
    logic      dmp_we;
    bus_addr_t dmp_addr;
    char_t     dmp_wdata;
    logic      dmp_ack;

    // reader side
    logic      con_req;
    logic      con_we;
    bus_addr_t con_addr;
    logic      con_ack;
    logic      dump_req;

    // shared bus into the core
    logic      bus_req;
    logic      bus_we;
    bus_addr_t bus_addr;
    bus_data_t bus_wdata;
    logic      bus_ack;
    bus_data_t bus_rdata;

    telemetry_dumper u_dumper (
        .clk        (clk),
        .resetn     (resetn),
        .start_i    (start_i),
        .dump_req_i (dump_req),
        .telem_i    (telem_i),
        .txrdy_n_i  (txrdy_n_o),
        .busy_o     (busy_o),
        .req_o      (dmp_req),
        .we_o       (dmp_we),
        .addr_o     (dmp_addr),
        .wdata_o    (dmp_wdata),
        .ack_i      (dmp_ack)
    );

    console_reader u_reader (
        .clk        (clk),
        .resetn     (resetn),
        .rxrdy_n_i  (rxrdy_n_o),
        .req_o      (con_req),
        .we_o       (con_we),
        .addr_o     (con_addr),
        .ack_i      (con_ack),
        .rdata_i    (bus_rdata),
        .dump_req_o (dump_req)
    );

    bus_arbiter u_arbiter (
        .clk         (clk),
        .resetn      (resetn),
        .dmp_req_i   (dmp_req),
        .dmp_we_i    (dmp_we),
        .dmp_addr_i  (dmp_addr),
        .dmp_wdata_i (dmp_wdata),
        .dmp_ack_o   (dmp_ack),
        .con_req_i   (con_req),
        .con_we_i    (con_we),
        .con_addr_i  (con_addr),
        .con_wdata_i ('0),        // reader never writes
        .con_ack_o   (con_ack),
        .bus_req_o   (bus_req),
        .bus_we_o    (bus_we),
        .bus_addr_o  (bus_addr),
        .bus_wdata_o (bus_wdata),
        .bus_ack_i   (bus_ack)
    );

    uart_core u_uart (
        .clk       (clk),
        .resetn    (resetn),
        .req_i     (bus_req),
        .we_i      (bus_we),
        .addr_i    (bus_addr),
        .wdata_i   (bus_wdata),
        .ack_o     (bus_ack),
        .rdata_o   (bus_rdata),
        .sin_i     (sin_i),
        .sout_o    (sout_o),
        .rxrdy_n_o (rxrdy_n_o),
        .txrdy_n_o (txrdy_n_o)
    );

endmodule

// File: testbench/tb_serial_tasks.svh
//--------------------
// serial line tasks for the testbench, 8N1 at CLKS_PER_BIT clocks per bit
// expects clk, sin and sout in the including module
//--------------------

`ifndef TB_SERIAL_TASKS_SVH
`define TB_SERIAL_TASKS_SVH

// one 8N1 frame on sin, lsb first, edges 1 ns after the clock
task automatic send_byte(input bus_data_t data);
    @(posedge clk);
    #1 sin = 1'b0;   // start bit
    repeat (CLKS_PER_BIT) @(posedge clk);
    for (int i = 0; i < 8; i++) begin
        #1 sin = data[i];
        repeat (CLKS_PER_BIT) @(posedge clk);
    end
    #1 sin = 1'b1;   // stop bit, line stays idle afterwards
    repeat (CLKS_PER_BIT) @(posedge clk);
endtask

// waits for the next start bit on sout and samples each bit at mid period
task automatic capture_byte(output char_t data);
    do begin
        @(negedge clk);
    end while (sout !== 1'b0);
    // first low sample is half a clock into the start bit
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    check_value("sout_o start bit", sout, 1'b0);
    for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        data[i] = sout;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    check_value("sout_o stop bit", sout, 1'b1);
endtask

`endif

// File: testbench/tb_debug_uart.sv
//--------------------
// text on sout is checked against a model of the line format
// telemetry inputs only change while no dump runs
//--------------------

`timescale 1ns/1ps

module tb_debug_uart
    import uart_bus_pkg::*;
    import telemetry_pkg::*;
();

    localparam int DUMP_CHARS     = TELEM_WORDS * CHARS_PER_WORD;
    localparam int TIMEOUT_CYCLES = 4 * DUMP_CHARS * FRAME_BITS * CLKS_PER_BIT * 3 / 2;

    logic        clk;
    logic        resetn;
    logic        start;
    logic        sin;
    telem_set_t  telem;
    logic        sout;
    logic        rxrdy_n;
    logic        txrdy_n;
    logic        busy;
    logic [31:0] lcg_state = 32'ha10b;
    char_t       got_q[$];   // chars seen on sout
    char_t       exp_q[$];   // chars from the model

    debug_uart_top UUT (
        .clk       (clk),
        .resetn    (resetn),
        .start_i   (start),
        .sin_i     (sin),
        .telem_i   (telem),
        .sout_o    (sout),
        .rxrdy_n_o (rxrdy_n),
        .txrdy_n_o (txrdy_n),
        .busy_o    (busy)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    `include "tb_serial_tasks.svh"

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic char_t to_hex_ascii(input logic [3:0] nib);
        string digits = "0123456789ABCDEF";
        return digits[nib];
    endfunction

    // one line per word with index, value, lf and cr
    function automatic void build_expected(input telem_set_t vals);
        logic [7:0] idx;
        exp_q.delete();
        for (int w = 0; w < TELEM_WORDS; w++) begin
            idx = 8'(w);
            exp_q.push_back(to_hex_ascii(idx[7:4]));
            exp_q.push_back(to_hex_ascii(idx[3:0]));
            for (int n = 3; n >= 0; n--) begin
                exp_q.push_back(to_hex_ascii(vals[w][4*n +: 4]));   // msb nibble first
            end
            exp_q.push_back(8'h0a);
            exp_q.push_back(8'h0d);
        end
    endfunction

    task automatic load_telem();
        logic [31:0] r;
        @(posedge clk);
        #1;
        for (int w = 0; w < TELEM_WORDS; w++) begin
            r = next_random();
            telem[w] = r[31:16];
        end
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
    endtask

    task automatic wait_busy_high();
        do begin
            @(negedge clk);
        end while (busy !== 1'b1);
    endtask

    // rxrdy_n low for a new byte, then high once the reader took it
    task automatic watch_rx_read();
        do begin
            @(negedge clk);
        end while (rxrdy_n !== 1'b0);
        do begin
            @(negedge clk);
        end while (rxrdy_n !== 1'b1);
    endtask

    task automatic check_quiet(input int bits);
        repeat (bits * CLKS_PER_BIT) begin
            @(negedge clk);
            check_value("sout_o", sout, 1'b1);
            check_value("busy_o", busy, 1'b0);
        end
    endtask

    // waits out a running dump, compares the text and sees no dump follow
    task automatic check_dump();
        do begin
            @(negedge clk);
        end while (busy !== 1'b0);
        do begin
            @(negedge clk);
        end while (txrdy_n !== 1'b0);   // last frame is out
        build_expected(telem);
        check_value("char count", got_q.size(), exp_q.size());
        foreach (exp_q[i]) begin
            check_value($sformatf("sout_o char %0d", i), got_q[i], exp_q[i]);
        end
        check_quiet(20);
    endtask

    // serial monitor
    initial begin
        char_t c;
        @(posedge resetn);
        forever begin
            capture_byte(c);
            got_q.push_back(c);
        end
    end

    initial begin
        int cycle_cnt;
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout, the tests did not finish within %0d clock cycles", cycle_cnt);
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    initial begin
        logic [31:0] r;
        char_t       other;
        resetn = 1'b0;
        start  = 1'b0;
        sin    = 1'b1;
        telem  = '0;
        repeat (2) @(posedge clk);
        #1 resetn = 1'b1;

        // idle levels out of reset
        @(negedge clk);
        check_value("sout_o", sout, 1'b1);
        check_value("busy_o", busy, 1'b0);
        check_value("txrdy_n_o", txrdy_n, 1'b1);
        check_value("rxrdy_n_o", rxrdy_n, 1'b1);

        // dump on start_i
        load_telem();
        got_q.delete();
        pulse_start();
        wait_busy_high();
        check_dump();

        // dump on the command char
        got_q.delete();
        fork
            send_byte(CMD_DUMP);
            watch_rx_read();
        join
        wait_busy_high();
        check_dump();

        // any other char is drained without a dump
        do begin
            r     = next_random();
            other = r[7:0];
        end while (other == CMD_DUMP);
        fork
            send_byte(other);
            watch_rx_read();
        join
        check_quiet(20);

        // triggers while busy are dropped
        got_q.delete();
        pulse_start();
        wait_busy_high();
        r = next_random();
        repeat (int'(r[9:0])) @(posedge clk);
        pulse_start();
        fork
            send_byte(CMD_DUMP);
            watch_rx_read();
        join
        @(negedge clk);
        check_value("busy_o", busy, 1'b1);
        check_dump();

        // second start_i dump with fresh values
        load_telem();
        got_q.delete();
        pulse_start();
        wait_busy_high();
        check_dump();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: debug_uart.f
common/uart_bus_pkg.sv
common/telemetry_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_core.sv
design/bus_arbiter.sv
design/telemetry_dumper.sv
design/console_reader.sv
design/debug_uart_top.sv
+incdir+testbench
testbench/tb_debug_uart.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the testbench with Verilator
# the result is taken from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f debug_uart.f --top-module tb_debug_uart \
    && ./obj_dir/Vtb_debug_uart 2>&1 | tee sim.log

grep -q "SIMULATION PASSED" sim.log && echo "run_sim: pass" && exit 0
echo "run_sim: fail, see sim.log" || true
exit 1
